// File: hdl/exec_pkg.sv
/*
 * Shared widths and encodings for the execute stage.
 * Holds the one-hot functional unit bit positions and the micro-op codes
 * for the ALU, control-flow and load/store units. Modules refer to these
 * through exec_pkg:: scoped names.
 */
`default_nettype none

package exec_pkg;

    // Widths ------------------------------------------------------------------
    localparam int XLEN    = 32;          // Data path width
    localparam int FU_W    = 4;           // One-hot unit select width
    localparam int UOP_W   = 5;           // Micro-op width
    localparam int REG_W   = 5;           // Register address width
    localparam int SIZE_W  = 2;           // Instruction size width
    localparam int INSTR_W = 32;          // Instruction word width

    // Functional unit select bits -----------------------------------------
    localparam int P_FU_ALU = 0;          // Integer ALU
    localparam int P_FU_LSU = 1;          // Load/store address generation
    localparam int P_FU_CFU = 2;          // Branches and jumps
    localparam int P_FU_CSR = 3;          // CSR access, operands pass through

    // ALU micro-ops
    localparam logic [UOP_W-1:0] ALU_ADD  = 5'd0;
    localparam logic [UOP_W-1:0] ALU_SUB  = 5'd1;
    localparam logic [UOP_W-1:0] ALU_XOR  = 5'd2;
    localparam logic [UOP_W-1:0] ALU_OR   = 5'd3;
    localparam logic [UOP_W-1:0] ALU_AND  = 5'd4;
    localparam logic [UOP_W-1:0] ALU_SLL  = 5'd5;
    localparam logic [UOP_W-1:0] ALU_SRL  = 5'd6;
    localparam logic [UOP_W-1:0] ALU_SRA  = 5'd7;
    localparam logic [UOP_W-1:0] ALU_SLT  = 5'd8;
    localparam logic [UOP_W-1:0] ALU_SLTU = 5'd9;

    // CFU micro-ops, anything below 8 is a conditional branch
    localparam logic [UOP_W-1:0] CFU_BEQ       = 5'd0;
    localparam logic [UOP_W-1:0] CFU_BNE       = 5'd1;
    localparam logic [UOP_W-1:0] CFU_BLT       = 5'd2;
    localparam logic [UOP_W-1:0] CFU_BGE       = 5'd3;
    localparam logic [UOP_W-1:0] CFU_BLTU      = 5'd4;
    localparam logic [UOP_W-1:0] CFU_BGEU      = 5'd5;
    localparam logic [UOP_W-1:0] CFU_JALI      = 5'd16; // Jump to immediate target
    localparam logic [UOP_W-1:0] CFU_JALR      = 5'd17; // Jump to register + offset
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'd24; // Resolved branch, taken
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'd25; // Resolved branch, fall through

    // LSU micro-op bit positions
    localparam int LSU_LOAD  = 0;         // Load request
    localparam int LSU_STORE = 1;         // Store request

endpackage

`default_nettype wire

// File: hdl/exec_alu.sv
/*
 * Single-cycle integer ALU for the execute stage.
 * Result is zero unless the ALU unit is selected. The adder and the
 * comparator flags are always live for address, jump and branch use.
 */
`default_nettype none

module exec_alu #(
    parameter int XLEN = exec_pkg::XLEN
) (
    input  wire                        i_fu_alu,       // ALU selected
    input  wire [exec_pkg::UOP_W-1:0]  i_uop,          // Micro-op
    input  wire                        i_cmp_unsigned, // Branch wants unsigned compare
    input  wire [XLEN-1:0]             i_lhs,          // Operand A
    input  wire [XLEN-1:0]             i_rhs,          // Operand B
    output logic [XLEN-1:0]            o_result,       // Selected ALU result
    output logic [XLEN-1:0]            o_add_result,   // Always-valid sum
    output logic                       o_lt,           // lhs < rhs
    output logic                       o_eq            // lhs == rhs
);

    localparam int SHW = $clog2(XLEN);    // Shift amount width

    // Operation decode ----------------------------------------------------
    logic op_add;
    logic op_sub;
    logic op_xor;
    logic op_or;
    logic op_and;
    logic op_sll;
    logic op_srl;
    logic op_sra;
    logic op_slt;
    logic op_sltu;
    logic cmp_unsigned;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] sub_result;

    assign op_add  = i_fu_alu && (i_uop == exec_pkg::ALU_ADD);
    assign op_sub  = i_fu_alu && (i_uop == exec_pkg::ALU_SUB);
    assign op_xor  = i_fu_alu && (i_uop == exec_pkg::ALU_XOR);
    assign op_or   = i_fu_alu && (i_uop == exec_pkg::ALU_OR);
    assign op_and  = i_fu_alu && (i_uop == exec_pkg::ALU_AND);
    assign op_sll  = i_fu_alu && (i_uop == exec_pkg::ALU_SLL);
    assign op_srl  = i_fu_alu && (i_uop == exec_pkg::ALU_SRL);
    assign op_sra  = i_fu_alu && (i_uop == exec_pkg::ALU_SRA);
    assign op_slt  = i_fu_alu && (i_uop == exec_pkg::ALU_SLT);
    assign op_sltu = i_fu_alu && (i_uop == exec_pkg::ALU_SLTU);

    // Arithmetic and compare ----------------------------------------------
    assign o_add_result = i_lhs + i_rhs;          // Also address / jalr target
    assign sub_result   = i_lhs - i_rhs;
    assign shamt        = i_rhs[SHW-1:0];         // Low bits only

    assign cmp_unsigned = op_sltu || i_cmp_unsigned;
    assign o_eq = (i_lhs == i_rhs);
    assign o_lt = cmp_unsigned ? (i_lhs < i_rhs)
                               : ($signed(i_lhs) < $signed(i_rhs));

    // Result mux, one-hot by decode
    assign o_result = {XLEN{op_add}} & o_add_result                       |
                      {XLEN{op_sub}} & sub_result                         |
                      {XLEN{op_xor}} & (i_lhs ^ i_rhs)                    |
                      {XLEN{op_or }} & (i_lhs | i_rhs)                    |
                      {XLEN{op_and}} & (i_lhs & i_rhs)                    |
                      {XLEN{op_sll}} & (i_lhs << shamt)                   |
                      {XLEN{op_srl}} & (i_lhs >> shamt)                   |
                      {XLEN{op_sra}} & $unsigned($signed(i_lhs) >>> shamt) |
                      {XLEN{op_slt || op_sltu}} & {{(XLEN-1){1'b0}}, o_lt};

endmodule

`default_nettype wire

// File: hdl/exec_branch.sv
/*
 * Control-flow decode for the execute stage.
 * Resolves conditional branches to taken / not taken from the ALU flags
 * and forms the bit-0-cleared jump target.
 */
`default_nettype none

module exec_branch #(
    parameter int XLEN = exec_pkg::XLEN
) (
    input  wire                        i_fu_cfu,       // CFU selected
    input  wire [exec_pkg::UOP_W-1:0]  i_uop,          // Incoming micro-op
    input  wire                        i_lt,           // ALU less-than
    input  wire                        i_eq,           // ALU equal
    input  wire [XLEN-1:0]             i_add_result,   // rs1 + offset for jalr
    input  wire [XLEN-1:0]             i_opr_c,        // Precomputed pc-relative target
    output logic                       o_cmp_unsigned, // Tell ALU to compare unsigned
    output logic [exec_pkg::UOP_W-1:0] o_uop,          // Rewritten micro-op
    output logic [XLEN-1:0]            o_target        // Jump / branch target
);

    logic cond;
    logic taken;
    logic jalr;

    assign cond = i_fu_cfu && (i_uop[exec_pkg::UOP_W-1:3] == '0); // uop < 8
    assign jalr = i_fu_cfu && (i_uop == exec_pkg::CFU_JALR);

    // Unsigned compare only for bltu / bgeu
    assign o_cmp_unsigned = i_fu_cfu && ((i_uop == exec_pkg::CFU_BLTU) ||
                                         (i_uop == exec_pkg::CFU_BGEU));

    // bge/bgeu share !lt, signedness chosen above
    assign taken = (i_uop == exec_pkg::CFU_BEQ)  &&  i_eq ||
                   (i_uop == exec_pkg::CFU_BNE)  && !i_eq ||
                   (i_uop == exec_pkg::CFU_BLT)  &&  i_lt ||
                   (i_uop == exec_pkg::CFU_BGE)  && !i_lt ||
                   (i_uop == exec_pkg::CFU_BLTU) &&  i_lt ||
                   (i_uop == exec_pkg::CFU_BGEU) && !i_lt;

    assign o_uop = !cond ? i_uop                  :  // Jumps keep their code
                   taken ? exec_pkg::CFU_TAKEN     :
                           exec_pkg::CFU_NOT_TAKEN;

    assign o_target = jalr ? {i_add_result[XLEN-1:1], 1'b0}
                           : {i_opr_c[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

// File: hdl/exec_result_sel.sv
/*
 * Result selection for the execute stage.
 * Merges the unit results into the next operand A and B values, picks the
 * micro-op, makes the operand register load enables and drives the
 * forwarding values seen by the decode stage.
 */
`default_nettype none

module exec_result_sel #(
    parameter int XLEN = exec_pkg::XLEN
) (
    input  wire                        i_valid,      // s2 instruction present
    input  wire                        i_busy,       // Stage cannot accept
    input  wire [exec_pkg::FU_W-1:0]   i_fu,         // One-hot unit select
    input  wire [exec_pkg::UOP_W-1:0]  i_uop,        // Incoming micro-op
    input  wire [exec_pkg::REG_W-1:0]  i_rd,         // Destination, trap cause if trapped
    input  wire                        i_trap,       // Incoming trap
    input  wire [XLEN-1:0]             i_opr_a,      // Operand A
    input  wire [XLEN-1:0]             i_opr_c,      // Operand C
    input  wire [XLEN-1:0]             i_alu_result, // ALU result
    input  wire [XLEN-1:0]             i_add_result, // A + B
    input  wire [XLEN-1:0]             i_cfu_target, // Jump target
    input  wire [exec_pkg::UOP_W-1:0]  i_cfu_uop,    // Resolved CFU micro-op
    output logic [XLEN-1:0]            o_opr_a,      // Next s3 operand A
    output logic [XLEN-1:0]            o_opr_b,      // Next s3 operand B
    output logic [exec_pkg::UOP_W-1:0] o_uop,        // Next s3 micro-op
    output logic                       o_ld_a,       // Load operand A register
    output logic                       o_ld_b,       // Load operand B register
    output logic [XLEN-1:0]            o_fwd_wdata,  // Forwarded write data
    output logic                       o_fwd_load,   // Load in flight
    output logic                       o_fwd_csr     // CSR op in flight
);

    logic fu_alu;
    logic fu_lsu;
    logic fu_cfu;
    logic fu_csr;
    logic accept;
    logic lsu_store;

    assign fu_alu = i_fu[exec_pkg::P_FU_ALU];
    assign fu_lsu = i_fu[exec_pkg::P_FU_LSU];
    assign fu_cfu = i_fu[exec_pkg::P_FU_CFU];
    assign fu_csr = i_fu[exec_pkg::P_FU_CSR];

    assign accept    = i_valid && !i_busy;                    // Handshake this cycle
    assign lsu_store = fu_lsu && i_uop[exec_pkg::LSU_STORE];

    // Operand A, one unit at a time
    assign o_opr_a = {XLEN{fu_alu}} & i_alu_result |
                     {XLEN{fu_lsu}} & i_add_result |          // Memory address
                     {XLEN{fu_cfu}} & i_cfu_target |
                     {XLEN{fu_csr}} & i_opr_a;

    // Operand B carries store data, CSR data or the trap cause
    assign o_opr_b = i_trap            ? {{(XLEN-exec_pkg::REG_W){1'b0}}, i_rd} :
                     fu_lsu || fu_csr  ? i_opr_c                              :
                                         '0;

    assign o_uop  = fu_cfu ? i_cfu_uop : i_uop;
    assign o_ld_a = accept;
    assign o_ld_b = accept && (lsu_store || fu_csr || i_trap); // B kept otherwise

    // Forwarding toward decode
    assign o_fwd_wdata = i_alu_result;
    assign o_fwd_load  = fu_lsu && i_uop[exec_pkg::LSU_LOAD];
    assign o_fwd_csr   = fu_csr;

endmodule

`default_nettype wire

// File: hdl/exec_pipe_reg.sv
/*
 * Valid/busy pipeline register with flush and a typed payload.
 * Loads on i_valid while not busy, holds while the next stage stalls and
 * clears to zero on reset or flush.
 */
`default_nettype none

module exec_pipe_reg #(
    parameter type T_PAYLOAD = logic
) (
    input  wire           g_clk,    // Clock
    input  wire           g_resetn, // Sync reset, active low
    input  wire           i_valid,  // Upstream data valid
    input  wire T_PAYLOAD i_data,   // Upstream data
    input  wire           i_flush,  // Clear contents
    input  wire           i_busy,   // Downstream stalled
    output T_PAYLOAD      o_data,   // Registered data
    output logic          o_valid,  // Registered data valid
    output logic          o_busy    // Back-pressure to upstream
);

    logic load;

    assign o_busy = o_valid && i_busy;   // Stall only with something held
    assign load   = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else if (load) begin
            o_valid <= 1'b1;
            o_data  <= i_data;
        end else if (!o_busy) begin
            o_valid <= 1'b0;             // Drained, nothing new
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_stage.sv
/*
 * Execute stage of the in-order pipeline.
 * Takes one decoded instruction per cycle from s2, computes its result in
 * a single cycle and registers it toward s3 under valid/busy/flush.
 */
`default_nettype none

module exec_stage #(
    parameter int XLEN = exec_pkg::XLEN
) (
    input  wire                          g_clk,       // Clock
    input  wire                          g_resetn,    // Sync reset, active low

    input  wire                          i_s2_valid,  // Decoded instruction valid
    input  wire [exec_pkg::REG_W-1:0]    i_s2_rd,     // Destination register
    input  wire [XLEN-1:0]               i_s2_opr_a,  // Operand A
    input  wire [XLEN-1:0]               i_s2_opr_b,  // Operand B
    input  wire [XLEN-1:0]               i_s2_opr_c,  // Operand C
    input  wire [exec_pkg::UOP_W-1:0]    i_s2_uop,    // Micro-op
    input  wire [exec_pkg::FU_W-1:0]     i_s2_fu,     // One-hot unit select
    input  wire                          i_s2_trap,   // Raise a trap
    input  wire [exec_pkg::SIZE_W-1:0]   i_s2_size,   // Instruction size
    input  wire [exec_pkg::INSTR_W-1:0]  i_s2_instr,  // Instruction word
    output logic                         o_s2_busy,   // Stage cannot accept

    input  wire                          i_flush,     // Flush the stage

    output logic [exec_pkg::REG_W-1:0]   o_fwd_rd,    // Forwarded destination
    output logic [XLEN-1:0]              o_fwd_wdata, // Forwarded write data
    output logic                         o_fwd_load,  // Load in this stage
    output logic                         o_fwd_csr,   // CSR op in this stage

    output logic                         o_s3_valid,  // s3 item valid
    output logic [exec_pkg::REG_W-1:0]   o_s3_rd,
    output logic [XLEN-1:0]              o_s3_opr_a,
    output logic [XLEN-1:0]              o_s3_opr_b,
    output logic [exec_pkg::UOP_W-1:0]   o_s3_uop,
    output logic [exec_pkg::FU_W-1:0]    o_s3_fu,
    output logic                         o_s3_trap,
    output logic [exec_pkg::SIZE_W-1:0]  o_s3_size,
    output logic [exec_pkg::INSTR_W-1:0] o_s3_instr,
    input  wire                          i_s3_busy    // s3 stalled
);

    // Control payload, travels with o_s3_valid
    typedef struct packed {
        logic [exec_pkg::REG_W-1:0]   rd;
        logic [exec_pkg::UOP_W-1:0]   uop;
        logic [exec_pkg::FU_W-1:0]    fu;
        logic                         trap;
        logic [exec_pkg::SIZE_W-1:0]  size;
        logic [exec_pkg::INSTR_W-1:0] instr;
    } ctrl_t;

    logic [XLEN-1:0]            alu_result;
    logic [XLEN-1:0]            add_result;
    logic                       alu_lt;
    logic                       alu_eq;
    logic                       cmp_unsigned;
    logic [exec_pkg::UOP_W-1:0] cfu_uop;
    logic [XLEN-1:0]            cfu_target;
    logic [XLEN-1:0]            n_opr_a;
    logic [XLEN-1:0]            n_opr_b;
    logic [exec_pkg::UOP_W-1:0] n_uop;
    logic                       ld_a;
    logic                       ld_b;
    ctrl_t                      n_ctrl;
    ctrl_t                      s3_ctrl;

    // Functional units ----------------------------------------------------
    exec_alu #(.XLEN(XLEN)) u_alu (
        .i_fu_alu       (i_s2_fu[exec_pkg::P_FU_ALU]),
        .i_uop          (i_s2_uop),
        .i_cmp_unsigned (cmp_unsigned),
        .i_lhs          (i_s2_opr_a),
        .i_rhs          (i_s2_opr_b),
        .o_result       (alu_result),
        .o_add_result   (add_result),
        .o_lt           (alu_lt),
        .o_eq           (alu_eq)
    );

    exec_branch #(.XLEN(XLEN)) u_branch (
        .i_fu_cfu       (i_s2_fu[exec_pkg::P_FU_CFU]),
        .i_uop          (i_s2_uop),
        .i_lt           (alu_lt),
        .i_eq           (alu_eq),
        .i_add_result   (add_result),
        .i_opr_c        (i_s2_opr_c),
        .o_cmp_unsigned (cmp_unsigned),
        .o_uop          (cfu_uop),
        .o_target       (cfu_target)
    );

    exec_result_sel #(.XLEN(XLEN)) u_result_sel (
        .i_valid        (i_s2_valid),
        .i_busy         (o_s2_busy),
        .i_fu           (i_s2_fu),
        .i_uop          (i_s2_uop),
        .i_rd           (i_s2_rd),
        .i_trap         (i_s2_trap),
        .i_opr_a        (i_s2_opr_a),
        .i_opr_c        (i_s2_opr_c),
        .i_alu_result   (alu_result),
        .i_add_result   (add_result),
        .i_cfu_target   (cfu_target),
        .i_cfu_uop      (cfu_uop),
        .o_opr_a        (n_opr_a),
        .o_opr_b        (n_opr_b),
        .o_uop          (n_uop),
        .o_ld_a         (ld_a),
        .o_ld_b         (ld_b),
        .o_fwd_wdata    (o_fwd_wdata),
        .o_fwd_load     (o_fwd_load),
        .o_fwd_csr      (o_fwd_csr)
    );

    assign o_fwd_rd = i_s2_rd;

    // Pipeline registers --------------------------------------------------
    assign n_ctrl = '{rd: i_s2_rd, uop: n_uop, fu: i_s2_fu, trap: i_s2_trap,
                      size: i_s2_size, instr: i_s2_instr};

    exec_pipe_reg #(.T_PAYLOAD(ctrl_t)) u_ctrl_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (i_s2_valid),  // Accepts when not busy
        .i_data   (n_ctrl),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (s3_ctrl),
        .o_valid  (o_s3_valid),
        .o_busy   (o_s2_busy)
    );

    exec_pipe_reg #(.T_PAYLOAD(logic [XLEN-1:0])) u_opr_a_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (ld_a),
        .i_data   (n_opr_a),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (o_s3_opr_a),
        .o_valid  (),
        .o_busy   ()
    );

    exec_pipe_reg #(.T_PAYLOAD(logic [XLEN-1:0])) u_opr_b_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (ld_b),        // Store, CSR or trap only
        .i_data   (n_opr_b),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (o_s3_opr_b),
        .o_valid  (),
        .o_busy   ()
    );

    assign o_s3_rd    = s3_ctrl.rd;
    assign o_s3_uop   = s3_ctrl.uop;
    assign o_s3_fu    = s3_ctrl.fu;
    assign o_s3_trap  = s3_ctrl.trap;
    assign o_s3_size  = s3_ctrl.size;
    assign o_s3_instr = s3_ctrl.instr;

endmodule

`default_nettype wire

// File: sim/exec_stage_properties.sv
/*
 * Concurrent assertions on the execute stage valid/busy/flush protocol.
 * Bound into exec_stage from the testbench.
 */
`default_nettype none

module exec_stage_properties #(
    parameter int XLEN = exec_pkg::XLEN
) (
    input wire                          g_clk,
    input wire                          g_resetn,
    input wire                          i_flush,
    input wire                          i_s3_busy,
    input wire                          o_s3_valid,
    input wire                          o_s2_busy,
    input wire [exec_pkg::REG_W-1:0]    o_s3_rd,
    input wire [XLEN-1:0]               o_s3_opr_a,
    input wire [XLEN-1:0]               o_s3_opr_b,
    input wire [exec_pkg::UOP_W-1:0]    o_s3_uop,
    input wire [exec_pkg::FU_W-1:0]     o_s3_fu,
    input wire                          o_s3_trap,
    input wire [exec_pkg::SIZE_W-1:0]   o_s3_size,
    input wire [exec_pkg::INSTR_W-1:0]  o_s3_instr
);

    // Reset empties s3
    a_reset: assert property (@(posedge g_clk) !g_resetn |=> !o_s3_valid)
        else $error("s3 valid after reset");

    // Held item stays put while s3 stalls
    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_s3_valid && i_s3_busy && !i_flush |=>
        o_s3_valid && $stable(o_s3_rd) && $stable(o_s3_opr_a) && $stable(o_s3_opr_b) &&
        $stable(o_s3_uop) && $stable(o_s3_fu) && $stable(o_s3_trap) &&
        $stable(o_s3_size) && $stable(o_s3_instr))
        else $error("s3 outputs changed under back-pressure");

    a_busy: assert property (@(posedge g_clk) o_s2_busy == (o_s3_valid && i_s3_busy))
        else $error("s2 busy does not follow s3 valid and busy");

    a_flush: assert property (@(posedge g_clk) disable iff (!g_resetn) i_flush |=> !o_s3_valid)
        else $error("s3 valid after flush");

endmodule

`default_nettype wire

// File: sim/tb_exec_stage.sv
/*
 * Testbench for the execute stage. Drives random and directed s2 items,
 * keeps expected s3 results in a queue from a reference function and
 * compares each item as the downstream consumes it.
 */
`default_nettype none

module tb_exec_stage;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  uop;
        logic [3:0]  fu;
        logic        trap;
        logic [1:0]  size;
        logic [31:0] instr;
    } item_t;

    logic        g_clk;
    logic        g_resetn;
    logic        i_s2_valid;
    logic [4:0]  i_s2_rd;
    logic [31:0] i_s2_opr_a;
    logic [31:0] i_s2_opr_b;
    logic [31:0] i_s2_opr_c;
    logic [4:0]  i_s2_uop;
    logic [3:0]  i_s2_fu;
    logic        i_s2_trap;
    logic [1:0]  i_s2_size;
    logic [31:0] i_s2_instr;
    logic        o_s2_busy;
    logic        i_flush;
    logic [4:0]  o_fwd_rd;
    logic [31:0] o_fwd_wdata;
    logic        o_fwd_load;
    logic        o_fwd_csr;
    logic        o_s3_valid;
    logic [4:0]  o_s3_rd;
    logic [31:0] o_s3_opr_a;
    logic [31:0] o_s3_opr_b;
    logic [4:0]  o_s3_uop;
    logic [3:0]  o_s3_fu;
    logic        o_s3_trap;
    logic [1:0]  o_s3_size;
    logic [31:0] o_s3_instr;
    logic        i_s3_busy;

    item_t       exp_q[$];       // Accepted, not yet consumed
    logic [31:0] last_b;         // Operand B register model
    logic        busy_en;        // Random back-pressure on
    logic        flush_seen;

    exec_stage #(.XLEN(32)) UUT (.*);

    always #4 g_clk = ~g_clk;

    // ------------------------------------------------------------------------
    function automatic item_t exec_ref(input logic [4:0] rd, input logic [31:0] a,
                                       input logic [31:0] b, input logic [31:0] c,
                                       input logic [4:0] uop, input logic [3:0] fu,
                                       input logic trap, input logic [1:0] size,
                                       input logic [31:0] instr, input logic [31:0] prev_b);
        item_t r;
        logic  tk;
        r = '{rd: rd, a: 32'h0, b: prev_b, uop: uop, fu: fu, trap: trap,
              size: size, instr: instr};
        if (fu[0]) begin
            case (uop)
                5'd0: r.a = a + b;
                5'd1: r.a = a - b;
                5'd2: r.a = a ^ b;
                5'd3: r.a = a | b;
                5'd4: r.a = a & b;
                5'd5: r.a = a << b[4:0];
                5'd6: r.a = a >> b[4:0];
                5'd7: r.a = $signed(a) >>> b[4:0];
                5'd8: r.a = {31'h0, $signed(a) < $signed(b)};
                5'd9: r.a = {31'h0, a < b};
                default: r.a = 32'h0;
            endcase
        end else if (fu[1]) begin
            r.a = a + b;                                 // Memory address
            if (uop[1]) r.b = c;                         // Store data
        end else if (fu[2]) begin
            r.a = (uop == 5'd17) ? ((a + b) & ~32'h1) : (c & ~32'h1);
            if (uop < 5'd8) begin
                case (uop)
                    5'd0: tk = (a == b);
                    5'd1: tk = (a != b);
                    5'd2: tk = $signed(a) < $signed(b);
                    5'd3: tk = $signed(a) >= $signed(b);
                    5'd4: tk = a < b;
                    default: tk = a >= b;
                endcase
                r.uop = tk ? 5'd24 : 5'd25;
            end
        end else if (fu[3]) begin
            r.a = a;                                     // CSR pass-through
            r.b = c;
        end
        if (trap) r.b = {27'h0, rd};                     // Cause
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout while %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // Drive one item and hold it until accepted
    task automatic issue(input logic [3:0] fu, input logic [4:0] uop, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] c, input logic trap);
        int    t;
        logic  done;
        item_t f;
        i_s2_valid = 1'b1;
        i_s2_fu    = fu;
        i_s2_uop   = uop;
        i_s2_opr_a = a;
        i_s2_opr_b = b;
        i_s2_opr_c = c;
        i_s2_trap  = trap;
        i_s2_rd    = 5'($urandom);
        i_s2_size  = 2'($urandom);
        i_s2_instr = $urandom;
        f = exec_ref(i_s2_rd, a, b, c, uop, fu, trap, i_s2_size, i_s2_instr, 32'h0);
        t = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge g_clk);
            check("fwd_rd", {27'h0, i_s2_rd}, {27'h0, o_fwd_rd});
            check("fwd_load", {31'h0, fu[1] & uop[0]}, {31'h0, o_fwd_load});
            check("fwd_csr", {31'h0, fu[3]}, {31'h0, o_fwd_csr});
            if (fu[0]) check("fwd_wdata", f.a, o_fwd_wdata);
            if (!o_s2_busy) done = 1'b1;
            t++;
            if (t > 200) give_up("waiting for s2 acceptance");
        end
        @(posedge g_clk);
        #1;
        i_s2_valid = 1'b0;
    endtask

    task automatic random_op();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom;
        b = ($urandom % 4 == 0) ? a : $urandom;
        case ($urandom % 4)
            0: issue(4'b0001, 5'($urandom % 10), a, b, $urandom, 1'b0);
            1: issue(4'b0010, 5'(1 + $urandom % 2), a, b, $urandom, 1'b0);
            2: issue(4'b0100, 5'($urandom % 6), a, b, $urandom, 1'b0);
            default: issue(4'b1000, 5'($urandom), a, b, $urandom, 1'b0);
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Random back-pressure from s3
    always @(posedge g_clk) begin
        #1;
        i_s3_busy = busy_en ? ($urandom % 3 == 0) : 1'b0;
    end

    // Push accepted items, pop and compare consumed ones
    always @(negedge g_clk) begin
        item_t e;
        if (!g_resetn) begin
            exp_q.delete();
            last_b = 32'h0;
        end else begin
            // Queue holds exactly the item sitting in s3
            check("s3_valid", {31'h0, exp_q.size() != 0}, {31'h0, o_s3_valid});
            check("busy_rule", {31'h0, (exp_q.size() != 0) && i_s3_busy}, {31'h0, o_s2_busy});
            if (flush_seen) check("valid_after_flush", 32'h0, {31'h0, o_s3_valid});
            flush_seen = i_flush;
            if (i_flush) begin
                exp_q.delete();                          // Flushed items never compared
                last_b = 32'h0;
            end else begin
                if (o_s3_valid && !i_s3_busy) begin
                    if (exp_q.size() == 0) begin
                        $display("Unexpected item on s3 with nothing outstanding");
                        $display("Simulation finished: FAIL");
                        $fatal(1);
                    end
                    e = exp_q.pop_front();
                    check("rd", {27'h0, e.rd}, {27'h0, o_s3_rd});
                    check("opr_a", e.a, o_s3_opr_a);
                    check("opr_b", e.b, o_s3_opr_b);
                    check("uop", {27'h0, e.uop}, {27'h0, o_s3_uop});
                    check("fu", {28'h0, e.fu}, {28'h0, o_s3_fu});
                    check("trap", {31'h0, e.trap}, {31'h0, o_s3_trap});
                    check("size", {30'h0, e.size}, {30'h0, o_s3_size});
                    check("instr", e.instr, o_s3_instr);
                end
                if (i_s2_valid && !o_s2_busy) begin
                    e = exec_ref(i_s2_rd, i_s2_opr_a, i_s2_opr_b, i_s2_opr_c, i_s2_uop,
                                 i_s2_fu, i_s2_trap, i_s2_size, i_s2_instr, last_b);
                    last_b = e.b;
                    exp_q.push_back(e);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    initial begin
        int t;
        void'($urandom(32'h9ffd0af5));
        g_clk = 1'b0;
        g_resetn = 1'b0;
        i_s2_valid = 1'b0;
        i_s2_rd = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop = '0;
        i_s2_fu = '0;
        i_s2_trap = 1'b0;
        i_s2_size = '0;
        i_s2_instr = '0;
        i_flush = 1'b0;
        i_s3_busy = 1'b0;
        busy_en = 1'b0;
        flush_seen = 1'b0;
        last_b = '0;
        repeat (4) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;

        // ALU sweep
        for (int i = 0; i < 40; i++) issue(4'b0001, 5'(i % 10), $urandom, $urandom, 0, 1'b0);
        // Branches, jumps
        for (int i = 0; i < 30; i++) begin
            t = $urandom;
            issue(4'b0100, 5'(i % 6), t, (i % 3 == 0) ? t : $urandom, $urandom, 1'b0);
        end
        issue(4'b0100, 5'd16, $urandom, $urandom, $urandom, 1'b0);
        issue(4'b0100, 5'd17, $urandom, $urandom, $urandom, 1'b0);
        // Load, store, CSR
        issue(4'b0010, 5'd1, $urandom, $urandom, $urandom, 1'b0);
        issue(4'b0010, 5'd2, $urandom, $urandom, $urandom, 1'b0);
        issue(4'b0010, 5'd1, $urandom, $urandom, $urandom, 1'b0);
        issue(4'b1000, 5'd3, $urandom, $urandom, $urandom, 1'b0);
        // Mixed traffic under back-pressure
        busy_en = 1'b1;
        for (int i = 0; i < 80; i++) random_op();
        busy_en = 1'b0;
        // Trap, then a flush of an item sitting in s3
        issue(4'b0001, 5'd0, $urandom, $urandom, $urandom, 1'b1);
        issue(4'b0001, 5'd2, $urandom, $urandom, $urandom, 1'b0);
        i_flush = 1'b1;
        @(posedge g_clk);
        #1;
        i_flush = 1'b0;
        issue(4'b0010, 5'd1, $urandom, $urandom, $urandom, 1'b0);

        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge g_clk);
            t++;
            if (t > 200) give_up("draining the result queue");
        end
        repeat (2) @(negedge g_clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

bind exec_stage exec_stage_properties #(.XLEN(XLEN)) u_props (.*);

`default_nettype wire

// File: list.f
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/exec_result_sel.sv
hdl/exec_pipe_reg.sv
hdl/exec_stage.sv
sim/exec_stage_properties.sv
sim/tb_exec_stage.sv

// File: Makefile
# Verilator flow for the execute stage

VERILATOR ?= verilator
TOP       ?= tb_exec_stage
RTL_TOP   ?= exec_stage
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

RTL_SRCS = hdl/exec_pkg.sv hdl/exec_alu.sv hdl/exec_branch.sv \
           hdl/exec_result_sel.sv hdl/exec_pipe_reg.sv hdl/exec_stage.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
